/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_nibble_bus
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_MSG ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR TIMESCALE VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_clock.sv */
`default_nettype none

module tb_clock (
	input logic reset_req,
	output logic strobe,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD_NS = 50;
	localparam int RESET_CYCLES = 8;
	localparam int RELEASE_DELAY_NS = 10;

	initial begin
		strobe = 1'b0;
		forever begin
			#HALF_PERIOD_NS;
			strobe = ~strobe;
		end
	end

	// power-on reset, then again on every request
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge strobe);
		#RELEASE_DELAY_NS;
		rst_n = 1'b1;
		forever begin
			@(posedge reset_req);
			rst_n = 1'b0;
			repeat (RESET_CYCLES) @(posedge strobe);
			#RELEASE_DELAY_NS;
			rst_n = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* dv/tb_nibble_bus.sv */
`default_nettype none

module tb_nibble_bus;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CYCLE_NS = 100;
	localparam int STIM_DELAY_NS = 10;
	localparam string ROM_FILE = "rtl/rom.hex";
	localparam int ADDR_MASK = (1 << nibble_bus_pkg::ADDR_W) - 1;
	localparam int ROM_LEN = nibble_bus_pkg::ROM_LEN;
	localparam int IO_LEN = nibble_bus_pkg::IO_RAM_LEN;
	localparam int SYS_LEN = nibble_bus_pkg::SYS_RAM_LEN;
	localparam int IO_BASE = 'h20000;
	localparam int SYS_BASE = 'h40000;
	localparam int NEW_IO_BASE = 'h80000;
	localparam int NEW_SYS_BASE = 'hc0100;
	localparam int OVERLAP_BASE = 'h30000;
	localparam int RUN_LEN = 16;
	localparam int RANDOM_CMDS = 600;
	// upper bounds on command counts, for the watchdog
	localparam int FIXED_CMDS = 200;
	localparam int MAX_RUNS = 8;
	localparam int FILL_CMDS = IO_LEN + SYS_LEN + 2;
	localparam int RESET_CMDS = 3 * 10;
	localparam int TOTAL_CMDS = FIXED_CMDS + FILL_CMDS + RANDOM_CMDS +
		MAX_RUNS * (2 * RUN_LEN + 2) + RESET_CMDS;
	localparam int TIMEOUT_NS = (TOTAL_CMDS + 50) * CYCLE_NS;

	logic strobe;
	logic rst_n;
	logic reset_req;
	logic [3:0] command;
	logic [19:0] address;
	logic [3:0] nibble_in;
	logic daisy_in;
	logic [3:0] nibble_out;
	logic data_valid;
	logic daisy_out;
	logic error;

	// reference model state
	int pc_m;
	int dp_m;
	int io_base_m;
	int sys_base_m;
	bit io_cfg_m;
	bit sys_cfg_m;
	bit err_m;
	logic [3:0] rom_img [ROM_LEN];
	logic [3:0] io_mem [IO_LEN];
	logic [3:0] sys_mem [SYS_LEN];
	bit io_known [IO_LEN];
	bit sys_known [SYS_LEN];

	int seed;
	int error_count;
	string test_name;

	tb_clock i_clock (
		.reset_req(reset_req),
		.strobe(strobe),
		.rst_n(rst_n)
	);

	nibble_bus_top i_nibble_bus_top (
		.strobe(strobe),
		.rst_n(rst_n),
		.command(command),
		.address(address),
		.nibble_in(nibble_in),
		.daisy_in(daisy_in),
		.nibble_out(nibble_out),
		.data_valid(data_valid),
		.daisy_out(daisy_out),
		.error(error)
	);

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("Error in %s, %s: expected %0h, actual %0h", test_name, what,
				expected, actual);
			$display("Regression failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	function automatic logic [3:0] rand_nibble();
		logic [31:0] r;
		r = $random(seed);
		return r[3:0];
	endfunction

	// addresses spread over rom, both ram windows and open space
	function automatic int pick_address();
		case (rand_below(4))
			0: return rand_below(ROM_LEN + 8);
			1: return IO_BASE - 4 + rand_below(IO_LEN + 8);
			2: return SYS_BASE - 4 + rand_below(SYS_LEN + 8);
			default: return rand_below(ADDR_MASK + 1);
		endcase
	endfunction

	function automatic bit in_window(input int ptr, input int base, input int len);
		return (ptr >= base) && (ptr - base < len);
	endfunction

	task automatic reset_model();
		pc_m = 0;
		dp_m = 0;
		io_base_m = 0;
		sys_base_m = 0;
		io_cfg_m = 1'b0;
		sys_cfg_m = 1'b0;
		err_m = 1'b0;
	endtask

	task automatic check_idle();
		check_value("data_valid", 32'(0), 32'(data_valid));
		check_value("error", 32'(0), 32'(error));
		check_value("daisy_out", 32'(0), 32'(daisy_out));
	endtask

	// drive one command, step the model, check what the edge produced
	task automatic issue(input logic [3:0] cmd, input int addr, input logic [3:0] wdata);
		int sel;
		int n_act;
		bit rd;
		bit wr;
		bit rom_act;
		bit io_act;
		bit sys_act;
		bit known;
		bit io_cfg_old;
		logic [3:0] exp_nib;
		command = cmd;
		address = addr[19:0];
		nibble_in = wdata;
		rd = (cmd == nibble_bus_pkg::BUSCMD_PC_READ) || (cmd == nibble_bus_pkg::BUSCMD_DP_READ);
		wr = (cmd == nibble_bus_pkg::BUSCMD_PC_WRITE) ||
			(cmd == nibble_bus_pkg::BUSCMD_DP_WRITE);
		sel = ((cmd == nibble_bus_pkg::BUSCMD_DP_READ) ||
			(cmd == nibble_bus_pkg::BUSCMD_DP_WRITE)) ? dp_m : pc_m;
		rom_act = (rd || wr) && (sel < ROM_LEN);
		io_act = (rd || wr) && io_cfg_m && in_window(sel, io_base_m, IO_LEN);
		sys_act = (rd || wr) && sys_cfg_m && in_window(sel, sys_base_m, SYS_LEN);
		n_act = int'(rom_act) + int'(io_act) + int'(sys_act);
		known = 1'b1;
		exp_nib = nibble_bus_pkg::UNCLAIMED_NIBBLE;
		if (n_act > 1) begin
			// no device is defined to win a conflict
			known = 1'b0;
			err_m = 1'b1;
		end else if (rom_act) begin
			exp_nib = rom_img[sel];
		end else if (io_act) begin
			exp_nib = io_mem[sel - io_base_m];
			known = io_known[sel - io_base_m];
		end else if (sys_act) begin
			exp_nib = sys_mem[sel - sys_base_m];
			known = sys_known[sel - sys_base_m];
		end
		if (wr && io_act) begin
			io_mem[sel - io_base_m] = wdata;
			io_known[sel - io_base_m] = 1'b1;
		end
		if (wr && sys_act) begin
			sys_mem[sel - sys_base_m] = wdata;
			sys_known[sel - sys_base_m] = 1'b1;
		end
		if (cmd >= 4'd10) begin
			err_m = 1'b1;
		end
		case (cmd)
			nibble_bus_pkg::BUSCMD_PC_READ, nibble_bus_pkg::BUSCMD_PC_WRITE:
				pc_m = (pc_m + 1) & ADDR_MASK;
			nibble_bus_pkg::BUSCMD_DP_READ, nibble_bus_pkg::BUSCMD_DP_WRITE:
				dp_m = (dp_m + 1) & ADDR_MASK;
			nibble_bus_pkg::BUSCMD_LOAD_PC: pc_m = addr & ADDR_MASK;
			nibble_bus_pkg::BUSCMD_LOAD_DP: dp_m = addr & ADDR_MASK;
			nibble_bus_pkg::BUSCMD_CONFIGURE: begin
				// sys ram sees the io ram's configured bit from before this edge
				io_cfg_old = io_cfg_m;
				if (!io_cfg_m && daisy_in) begin
					io_base_m = addr & ADDR_MASK;
					io_cfg_m = 1'b1;
				end
				if (!sys_cfg_m && io_cfg_old) begin
					sys_base_m = addr & ADDR_MASK;
					sys_cfg_m = 1'b1;
				end
			end
			nibble_bus_pkg::BUSCMD_RESET: begin
				io_cfg_m = 1'b0;
				sys_cfg_m = 1'b0;
				io_base_m = 0;
				sys_base_m = 0;
			end
			default: begin
			end
		endcase
		@(posedge strobe);
		#STIM_DELAY_NS;
		check_value("data_valid", 32'(rd), 32'(data_valid));
		if (rd && known) begin
			check_value("nibble_out", 32'(exp_nib), 32'(nibble_out));
		end
		check_value("error", 32'(err_m), 32'(error));
		check_value("daisy_out", 32'(sys_cfg_m), 32'(daisy_out));
	endtask

	task automatic apply_reset();
		command = nibble_bus_pkg::BUSCMD_NOP;
		reset_req = 1'b1;
		@(posedge rst_n);
		reset_req = 1'b0;
		reset_model();
		check_idle();
	endtask

	task automatic fill_window(input int base, input int len);
		issue(nibble_bus_pkg::BUSCMD_LOAD_DP, base, 4'h0);
		repeat (len) issue(nibble_bus_pkg::BUSCMD_DP_WRITE, 0, rand_nibble());
	endtask

	// write a run from start, reload, read it back
	task automatic run_across(input int start, input bit use_pc);
		logic [3:0] load_cmd;
		logic [3:0] wr_cmd;
		logic [3:0] rd_cmd;
		load_cmd = use_pc ? nibble_bus_pkg::BUSCMD_LOAD_PC : nibble_bus_pkg::BUSCMD_LOAD_DP;
		wr_cmd = use_pc ? nibble_bus_pkg::BUSCMD_PC_WRITE : nibble_bus_pkg::BUSCMD_DP_WRITE;
		rd_cmd = use_pc ? nibble_bus_pkg::BUSCMD_PC_READ : nibble_bus_pkg::BUSCMD_DP_READ;
		issue(load_cmd, start, 4'h0);
		repeat (RUN_LEN) issue(wr_cmd, 0, rand_nibble());
		issue(load_cmd, start, 4'h0);
		repeat (RUN_LEN) issue(rd_cmd, 0, 4'h0);
	endtask

	task automatic test_reset_state();
		test_name = "reset state";
		repeat (8) begin
			issue(nibble_bus_pkg::BUSCMD_LOAD_PC, IO_BASE + rand_below(IO_LEN), 4'h0);
			issue(nibble_bus_pkg::BUSCMD_PC_READ, 0, 4'h0);
			issue(nibble_bus_pkg::BUSCMD_LOAD_PC, SYS_BASE + rand_below(SYS_LEN), 4'h0);
			issue(nibble_bus_pkg::BUSCMD_PC_READ, 0, 4'h0);
		end
		issue(nibble_bus_pkg::BUSCMD_LOAD_DP, rand_below(ROM_LEN - 16), 4'h0);
		repeat (16) issue(nibble_bus_pkg::BUSCMD_DP_READ, 0, 4'h0);
	endtask

	task automatic test_daisy_config();
		test_name = "daisy configuration";
		// chain input low, nobody takes it
		daisy_in = 1'b0;
		issue(nibble_bus_pkg::BUSCMD_CONFIGURE, 'h12345, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_LOAD_PC, 'h12345, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_PC_READ, 0, 4'h0);
		daisy_in = 1'b1;
		issue(nibble_bus_pkg::BUSCMD_CONFIGURE, IO_BASE, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_CONFIGURE, SYS_BASE, 4'h0);
		daisy_in = 1'b0;
		issue(nibble_bus_pkg::BUSCMD_CONFIGURE, 'h55555, 4'h0);
		fill_window(IO_BASE, IO_LEN);
		fill_window(SYS_BASE, SYS_LEN);
	endtask

	task automatic test_random_traffic();
		test_name = "random traffic";
		repeat (RANDOM_CMDS) begin
			case (rand_below(16))
				0, 1: issue(nibble_bus_pkg::BUSCMD_LOAD_PC, pick_address(), 4'h0);
				2, 3: issue(nibble_bus_pkg::BUSCMD_LOAD_DP, pick_address(), 4'h0);
				4, 5, 6: issue(nibble_bus_pkg::BUSCMD_PC_READ, 0, 4'h0);
				7, 8, 9: issue(nibble_bus_pkg::BUSCMD_DP_READ, 0, 4'h0);
				10, 11: issue(nibble_bus_pkg::BUSCMD_PC_WRITE, 0, rand_nibble());
				12, 13: issue(nibble_bus_pkg::BUSCMD_DP_WRITE, 0, rand_nibble());
				default: issue(nibble_bus_pkg::BUSCMD_NOP, pick_address(), rand_nibble());
			endcase
		end
	endtask

	task automatic test_auto_increment();
		test_name = "pointer auto-increment";
		run_across(IO_BASE + IO_LEN - RUN_LEN / 2, 1'b0);
		run_across(SYS_BASE - RUN_LEN / 2, 1'b0);
		run_across(SYS_BASE + SYS_LEN - RUN_LEN / 2, 1'b1);
		// rom swallows the writes
		run_across(ROM_LEN - RUN_LEN / 2, 1'b0);
	endtask

	task automatic test_reset_command();
		test_name = "reset command";
		issue(nibble_bus_pkg::BUSCMD_RESET, 0, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_LOAD_PC, IO_BASE + 5, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_PC_READ, 0, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_LOAD_PC, SYS_BASE + 100, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_PC_READ, 0, 4'h0);
		daisy_in = 1'b1;
		issue(nibble_bus_pkg::BUSCMD_CONFIGURE, NEW_IO_BASE, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_CONFIGURE, NEW_SYS_BASE, 4'h0);
		daisy_in = 1'b0;
		issue(nibble_bus_pkg::BUSCMD_LOAD_PC, IO_BASE + 5, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_PC_READ, 0, 4'h0);
		// old contents show up at the new base
		issue(nibble_bus_pkg::BUSCMD_LOAD_DP, NEW_SYS_BASE, 4'h0);
		repeat (8) issue(nibble_bus_pkg::BUSCMD_DP_READ, 0, 4'h0);
		run_across(NEW_IO_BASE + IO_LEN - RUN_LEN / 2, 1'b0);
		run_across(NEW_SYS_BASE - RUN_LEN / 2, 1'b1);
	endtask

	task automatic test_error_flag();
		test_name = "error flag";
		issue(4'd11, 0, 4'h0);
		repeat (3) issue(nibble_bus_pkg::BUSCMD_NOP, 0, 4'h0);
		apply_reset();
		// sys ram window starts inside the io ram window
		daisy_in = 1'b1;
		issue(nibble_bus_pkg::BUSCMD_CONFIGURE, OVERLAP_BASE, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_CONFIGURE, OVERLAP_BASE + 'h20, 4'h0);
		daisy_in = 1'b0;
		issue(nibble_bus_pkg::BUSCMD_LOAD_PC, OVERLAP_BASE + 'h30, 4'h0);
		issue(nibble_bus_pkg::BUSCMD_PC_READ, 0, 4'h0);
		repeat (2) issue(nibble_bus_pkg::BUSCMD_NOP, 0, 4'h0);
		apply_reset();
	endtask

	initial begin
		#TIMEOUT_NS;
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed = 90;
		error_count = 0;
		command = 4'h0;
		address = 20'h0;
		nibble_in = 4'h0;
		daisy_in = 1'b0;
		reset_req = 1'b0;
		test_name = "reset state";
		$readmemh(ROM_FILE, rom_img);
		reset_model();
		@(posedge rst_n);
		check_idle();
		test_reset_state();
		test_daisy_config();
		test_random_traffic();
		test_auto_increment();
		test_reset_command();
		test_error_flag();
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/boot_rom.sv */
`default_nettype none

module boot_rom (
	nibble_bus_if.device bus,
	output logic [nibble_bus_pkg::NIB_W-1:0] nibble,
	output logic active
);

	localparam string ROM_FILE = "rtl/rom.hex";
	localparam int IDX_W = $clog2(nibble_bus_pkg::ROM_LEN);

	logic [nibble_bus_pkg::ADDR_W-1:0] pc_ptr;
	logic [nibble_bus_pkg::ADDR_W-1:0] dp_ptr;
	logic [nibble_bus_pkg::ADDR_W-1:0] sel_ptr;
	logic is_dp_access;
	logic is_read;
	logic is_write;
	logic [nibble_bus_pkg::NIB_W-1:0] rom [nibble_bus_pkg::ROM_LEN];

	initial begin
		$readmemh(ROM_FILE, rom);
	end

	assign is_read = bus.command inside {nibble_bus_pkg::BUSCMD_PC_READ,
		nibble_bus_pkg::BUSCMD_DP_READ};
	assign is_write = bus.command inside {nibble_bus_pkg::BUSCMD_PC_WRITE,
		nibble_bus_pkg::BUSCMD_DP_WRITE};
	assign is_dp_access = bus.command inside {nibble_bus_pkg::BUSCMD_DP_READ,
		nibble_bus_pkg::BUSCMD_DP_WRITE};

	// base is fixed at zero
	assign sel_ptr = is_dp_access ? dp_ptr : pc_ptr;
	assign active = (is_read || is_write) &&
		(sel_ptr < nibble_bus_pkg::ADDR_W'(nibble_bus_pkg::ROM_LEN));

	// pointer tracking mirrors the RAM devices
	always_ff @(posedge bus.strobe or negedge bus.rst_n) begin
		if (!bus.rst_n) begin
			pc_ptr <= '0;
			dp_ptr <= '0;
		end else begin
			case (bus.command)
				nibble_bus_pkg::BUSCMD_PC_READ,
				nibble_bus_pkg::BUSCMD_PC_WRITE: begin
					pc_ptr <= pc_ptr + 1'b1;
				end
				nibble_bus_pkg::BUSCMD_DP_READ,
				nibble_bus_pkg::BUSCMD_DP_WRITE: begin
					dp_ptr <= dp_ptr + 1'b1;
				end
				nibble_bus_pkg::BUSCMD_LOAD_PC: begin
					pc_ptr <= bus.address;
				end
				nibble_bus_pkg::BUSCMD_LOAD_DP: begin
					dp_ptr <= bus.address;
				end
				default: begin
				end
			endcase
		end
	end

	// a claimed write lands nowhere
	always_ff @(posedge bus.strobe) begin
		if (active && is_read) begin
			nibble <= rom[sel_ptr[IDX_W-1:0]];
		end
	end

endmodule

`default_nettype wire

/* rtl/config_ram.sv */
`default_nettype none

module config_ram #(
	parameter int DEPTH = 64
) (
	nibble_bus_if.device bus,
	input logic daisy_in,
	output logic daisy_out,
	output logic [nibble_bus_pkg::NIB_W-1:0] nibble,
	output logic active,
	output logic error
);

	localparam int IDX_W = $clog2(DEPTH);

	logic configured;
	logic [nibble_bus_pkg::ADDR_W-1:0] base_addr;
	logic [nibble_bus_pkg::ADDR_W-1:0] pc_ptr;
	logic [nibble_bus_pkg::ADDR_W-1:0] dp_ptr;
	logic [nibble_bus_pkg::ADDR_W-1:0] sel_ptr;
	logic [nibble_bus_pkg::ADDR_W-1:0] offset;
	logic is_dp_access;
	logic is_read;
	logic is_write;
	logic in_range;
	logic mem_we;
	logic [nibble_bus_pkg::NIB_W-1:0] mem [DEPTH];

	// command decode
	assign is_read = bus.command inside {nibble_bus_pkg::BUSCMD_PC_READ,
		nibble_bus_pkg::BUSCMD_DP_READ};
	assign is_write = bus.command inside {nibble_bus_pkg::BUSCMD_PC_WRITE,
		nibble_bus_pkg::BUSCMD_DP_WRITE};
	assign is_dp_access = bus.command inside {nibble_bus_pkg::BUSCMD_DP_READ,
		nibble_bus_pkg::BUSCMD_DP_WRITE};

	// window check against base .. base + DEPTH - 1
	assign sel_ptr = is_dp_access ? dp_ptr : pc_ptr;
	assign offset = sel_ptr - base_addr;
	assign in_range = (sel_ptr >= base_addr) &&
		(offset < nibble_bus_pkg::ADDR_W'(DEPTH));

	assign active = (is_read || is_write) && in_range && configured;
	assign mem_we = active && is_write;
	assign daisy_out = configured;

	// pointers, configuration and error flag
	always_ff @(posedge bus.strobe or negedge bus.rst_n) begin
		if (!bus.rst_n) begin
			pc_ptr <= '0;
			dp_ptr <= '0;
			base_addr <= '0;
			configured <= 1'b0;
			error <= 1'b0;
		end else begin
			case (bus.command)
				nibble_bus_pkg::BUSCMD_PC_READ,
				nibble_bus_pkg::BUSCMD_PC_WRITE: begin
					pc_ptr <= pc_ptr + 1'b1;
				end
				nibble_bus_pkg::BUSCMD_DP_READ,
				nibble_bus_pkg::BUSCMD_DP_WRITE: begin
					dp_ptr <= dp_ptr + 1'b1;
				end
				nibble_bus_pkg::BUSCMD_LOAD_PC: begin
					pc_ptr <= bus.address;
				end
				nibble_bus_pkg::BUSCMD_LOAD_DP: begin
					dp_ptr <= bus.address;
				end
				nibble_bus_pkg::BUSCMD_CONFIGURE: begin
					// only the first unconfigured device in the chain takes it
					if (!configured && daisy_in) begin
						base_addr <= bus.address;
						configured <= 1'b1;
					end
				end
				nibble_bus_pkg::BUSCMD_RESET: begin
					base_addr <= '0;
					configured <= 1'b0;
				end
				default: begin
				end
			endcase
			if (bus.command >= nibble_bus_pkg::CMD_ILLEGAL_MIN) begin
				error <= 1'b1;
			end
		end
	end

	// storage and registered read data
	always_ff @(posedge bus.strobe) begin
		if (mem_we) begin
			mem[offset[IDX_W-1:0]] <= bus.wdata;
		end
		if (active && is_read) begin
			nibble <= mem[offset[IDX_W-1:0]];
		end
	end

	// unconfigured, the addressed storage slot keeps its contents
	assert property (@(posedge bus.strobe) disable iff (!bus.rst_n)
		!configured |=>
		mem[$past(offset[IDX_W-1:0])] === $past(mem[offset[IDX_W-1:0]]));

	// once configured, only RESET moves the base
	assert property (@(posedge bus.strobe) disable iff (!bus.rst_n)
		configured && bus.command != nibble_bus_pkg::BUSCMD_RESET
		|=> $stable(base_addr));

endmodule

`default_nettype wire

/* rtl/nibble_bus_if.sv */
`default_nettype none

interface nibble_bus_if (
	input logic strobe,
	input logic rst_n
);

	nibble_bus_pkg::bus_cmd_e command;
	logic [nibble_bus_pkg::ADDR_W-1:0] address;
	logic [nibble_bus_pkg::NIB_W-1:0] wdata;

	// host side drives the per-cycle command
	modport host (
		input  strobe,
		input  rst_n,
		output command,
		output address,
		output wdata
	);

	// every device only listens
	modport device (
		input strobe,
		input rst_n,
		input command,
		input address,
		input wdata
	);

endinterface

`default_nettype wire

/* rtl/nibble_bus_pkg.sv */
`default_nettype none

package nibble_bus_pkg;

	localparam int ADDR_W = 20;
	localparam int NIB_W = 4;
	localparam int CMD_W = 4;

	// device window lengths, in nibbles
	localparam int ROM_LEN = 256;
	localparam int IO_RAM_LEN = 64;
	localparam int SYS_RAM_LEN = 512;

	// returned when nobody claims a read
	localparam logic [NIB_W-1:0] UNCLAIMED_NIBBLE = 4'hf;

	// first code that no device understands
	localparam logic [CMD_W-1:0] CMD_ILLEGAL_MIN = 4'd10;

	// bus command codes
	// code 8 is the unconfigure slot, not modeled and treated as idle
	typedef enum logic [CMD_W-1:0] {
		BUSCMD_NOP       = 4'd0,
		BUSCMD_PC_READ   = 4'd1,
		BUSCMD_DP_READ   = 4'd2,
		BUSCMD_PC_WRITE  = 4'd3,
		BUSCMD_DP_WRITE  = 4'd4,
		BUSCMD_LOAD_PC   = 4'd5,
		BUSCMD_LOAD_DP   = 4'd6,
		BUSCMD_CONFIGURE = 4'd7,
		BUSCMD_RESET     = 4'd9
	} bus_cmd_e;

endpackage

`default_nettype wire

/* rtl/nibble_bus_top.sv */
`default_nettype none

module nibble_bus_top (
	input logic strobe,
	input logic rst_n,
	input logic [nibble_bus_pkg::CMD_W-1:0] command,
	input logic [nibble_bus_pkg::ADDR_W-1:0] address,
	input logic [nibble_bus_pkg::NIB_W-1:0] nibble_in,
	input logic daisy_in,
	output logic [nibble_bus_pkg::NIB_W-1:0] nibble_out,
	output logic data_valid,
	output logic daisy_out,
	output logic error
);

	logic [nibble_bus_pkg::NIB_W-1:0] rom_nibble;
	logic [nibble_bus_pkg::NIB_W-1:0] io_nibble;
	logic [nibble_bus_pkg::NIB_W-1:0] sys_nibble;
	logic rom_active;
	logic io_active;
	logic sys_active;
	logic io_error;
	logic sys_error;
	logic io_daisy_out;
	logic is_read;

	nibble_bus_if i_bus (
		.strobe(strobe),
		.rst_n(rst_n)
	);

	// host side of the bus
	assign i_bus.command = nibble_bus_pkg::bus_cmd_e'(command);
	assign i_bus.address = address;
	assign i_bus.wdata = nibble_in;

	assign is_read = i_bus.command inside {nibble_bus_pkg::BUSCMD_PC_READ,
		nibble_bus_pkg::BUSCMD_DP_READ};

	boot_rom i_boot_rom (
		.bus(i_bus),
		.nibble(rom_nibble),
		.active(rom_active)
	);

	// daisy chain runs io ram first, then sys ram
	config_ram #(
		.DEPTH(nibble_bus_pkg::IO_RAM_LEN)
	) i_io_ram (
		.bus(i_bus),
		.daisy_in(daisy_in),
		.daisy_out(io_daisy_out),
		.nibble(io_nibble),
		.active(io_active),
		.error(io_error)
	);

	config_ram #(
		.DEPTH(nibble_bus_pkg::SYS_RAM_LEN)
	) i_sys_ram (
		.bus(i_bus),
		.daisy_in(io_daisy_out),
		.daisy_out(daisy_out),
		.nibble(sys_nibble),
		.active(sys_active),
		.error(sys_error)
	);

	read_return i_read_return (
		.strobe(strobe),
		.rst_n(rst_n),
		.rom_nibble(rom_nibble),
		.io_nibble(io_nibble),
		.sys_nibble(sys_nibble),
		.rom_active(rom_active),
		.io_active(io_active),
		.sys_active(sys_active),
		.is_read(is_read),
		.io_error(io_error),
		.sys_error(sys_error),
		.nibble_out(nibble_out),
		.data_valid(data_valid),
		.error(error)
	);

endmodule

`default_nettype wire

/* rtl/read_return.sv */
`default_nettype none

module read_return (
	input logic strobe,
	input logic rst_n,
	input logic [nibble_bus_pkg::NIB_W-1:0] rom_nibble,
	input logic [nibble_bus_pkg::NIB_W-1:0] io_nibble,
	input logic [nibble_bus_pkg::NIB_W-1:0] sys_nibble,
	input logic rom_active,
	input logic io_active,
	input logic sys_active,
	input logic is_read,
	input logic io_error,
	input logic sys_error,
	output logic [nibble_bus_pkg::NIB_W-1:0] nibble_out,
	output logic data_valid,
	output logic error
);

	// bit 0 rom, bit 1 io ram, bit 2 sys ram
	logic [2:0] claim_q;
	logic conflict;
	logic conflict_q;

	assign conflict = (rom_active && io_active) || (rom_active && sys_active) ||
		(io_active && sys_active);

	always_ff @(posedge strobe or negedge rst_n) begin
		if (!rst_n) begin
			claim_q <= '0;
			data_valid <= 1'b0;
			conflict_q <= 1'b0;
		end else begin
			claim_q <= is_read ? {sys_active, io_active, rom_active} : 3'b000;
			data_valid <= is_read;
			// sticky until reset
			conflict_q <= conflict_q || conflict;
		end
	end

	// device flags are already registered and sticky
	assign error = conflict_q || io_error || sys_error;

	// steer the nibble of the device that answered
	always_comb begin
		if (claim_q[0]) begin
			nibble_out = rom_nibble;
		end else if (claim_q[1]) begin
			nibble_out = io_nibble;
		end else if (claim_q[2]) begin
			nibble_out = sys_nibble;
		end else begin
			nibble_out = nibble_bus_pkg::UNCLAIMED_NIBBLE;
		end
	end

	// back-to-back valid needs back-to-back reads
	assert property (@(posedge strobe) disable iff (!rst_n)
		data_valid && $past(data_valid) |-> $past(is_read) && $past(is_read, 2));

endmodule

`default_nettype wire

/* rtl/rom.hex */
// one nibble per entry, 16 per line; line n holds addresses 16n to 16n+15
5 6 7 8 9 a b c d e f 0 1 2 3 4
8 9 a b c d e f 0 1 2 3 4 5 6 7
b c d e f 0 1 2 3 4 5 6 7 8 9 a
e f 0 1 2 3 4 5 6 7 8 9 a b c d
1 2 3 4 5 6 7 8 9 a b c d e f 0
4 5 6 7 8 9 a b c d e f 0 1 2 3
7 8 9 a b c d e f 0 1 2 3 4 5 6
a b c d e f 0 1 2 3 4 5 6 7 8 9
d e f 0 1 2 3 4 5 6 7 8 9 a b c
0 1 2 3 4 5 6 7 8 9 a b c d e f
3 4 5 6 7 8 9 a b c d e f 0 1 2
6 7 8 9 a b c d e f 0 1 2 3 4 5
9 a b c d e f 0 1 2 3 4 5 6 7 8
c d e f 0 1 2 3 4 5 6 7 8 9 a b
f 0 1 2 3 4 5 6 7 8 9 a b c d e
2 3 4 5 6 7 8 9 a b c d e f 0 1

/* src.f */
rtl/nibble_bus_pkg.sv
rtl/nibble_bus_if.sv
rtl/boot_rom.sv
rtl/config_ram.sv
rtl/read_return.sv
rtl/nibble_bus_top.sv
dv/tb_clock.sv
dv/tb_nibble_bus.sv
